// File: Makefile
VERILATOR  ?= verilator
TOP        := tb_mips_core
RTL_TOP    := mips_core
FILELIST   := vlog.f
BUILD_DIR  := obj_dir
LINT_FLAGS := --lint-only -sv --timing
SIM_FLAGS  := --binary -sv --timing --assert -j 0

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)

// File: src/alu.sv
`timescale 1ns/1ps
`default_nettype none

module alu (
    input  mips_pkg::alu_op_e         i_op,
    input  logic [mips_pkg::XLEN-1:0] i_a,
    input  logic [mips_pkg::XLEN-1:0] i_b,
    output logic [mips_pkg::XLEN-1:0] o_result
);

    // Shifts move i_b by the amount in i_a
    always_comb begin
        o_result = '0;
        case (i_op)
            mips_pkg::ALU_ADD:  o_result = i_a + i_b;
            mips_pkg::ALU_SUB:  o_result = i_a - i_b;
            mips_pkg::ALU_AND:  o_result = i_a & i_b;
            mips_pkg::ALU_OR:   o_result = i_a | i_b;
            mips_pkg::ALU_XOR:  o_result = i_a ^ i_b;
            mips_pkg::ALU_NOR:  o_result = ~(i_a | i_b);
            mips_pkg::ALU_SLT:  o_result[0] = $signed(i_a) < $signed(i_b);
            mips_pkg::ALU_SLTU: o_result[0] = i_a < i_b;
            mips_pkg::ALU_SLL:  o_result = i_b << i_a[4:0];
            mips_pkg::ALU_SRL:  o_result = i_b >> i_a[4:0];
            mips_pkg::ALU_LUI:  o_result = {i_b[15:0], 16'h0000};
            default:            o_result = '0;
        endcase
    end

endmodule

`default_nettype wire

// File: src/decode_stage.sv
`timescale 1ns/1ps
`default_nettype none

module decode_stage (
    input  logic                            i_clk,
    input  logic                            i_rst_n,
    input  logic                            i_stall,
    input  logic [mips_pkg::XLEN-1:0]       i_pc,
    input  logic [mips_pkg::XLEN-1:0]       i_instr,
    input  logic [mips_pkg::XLEN-1:0]       i_rs_val,
    input  logic [mips_pkg::XLEN-1:0]       i_rt_val,
    output logic [mips_pkg::REG_ADDR_W-1:0] o_rs_addr,
    output logic [mips_pkg::REG_ADDR_W-1:0] o_rt_addr,
    output logic                            o_branch_taken,
    output logic [mips_pkg::XLEN-1:0]       o_branch_target,
    output logic [mips_pkg::XLEN-1:0]       o_dmem_addr,
    output logic [mips_pkg::XLEN-1:0]       o_dmem_wdata,
    output logic                            o_dmem_we,
    output mips_pkg::id_ex_t                o_id_ex
);

    mips_pkg::opcode_e         opcode;
    mips_pkg::funct_e          funct;
    mips_pkg::id_ex_t          id_ex_d;
    logic [mips_pkg::XLEN-1:0] imm_sext;
    logic [mips_pkg::XLEN-1:0] imm_zext;
    logic [mips_pkg::XLEN-1:0] pc_plus4;
    logic [mips_pkg::XLEN-1:0] br_target;
    logic [mips_pkg::XLEN-1:0] jmp_target;
    logic                      is_sw;

    assign opcode    = mips_pkg::opcode_e'(i_instr[31:26]);
    assign funct     = mips_pkg::funct_e'(i_instr[5:0]);
    assign o_rs_addr = i_instr[25:21];
    assign o_rt_addr = i_instr[20:16];

    assign imm_sext   = {{(mips_pkg::XLEN-16){i_instr[15]}}, i_instr[15:0]};
    assign imm_zext   = {{(mips_pkg::XLEN-16){1'b0}}, i_instr[15:0]};
    assign pc_plus4   = i_pc + 4;
    assign br_target  = pc_plus4 + {imm_sext[mips_pkg::XLEN-3:0], 2'b00};
    assign jmp_target = {pc_plus4[31:28], i_instr[25:0], 2'b00};

    always_comb begin
        id_ex_d         = '0;
        id_ex_d.pc      = i_pc;
        id_ex_d.alu_op  = mips_pkg::ALU_ADD;
        id_ex_d.a       = i_rs_val;
        id_ex_d.b       = imm_sext;
        id_ex_d.res_src = mips_pkg::RES_ALU;
        id_ex_d.rd      = i_instr[20:16];
        o_branch_taken  = 1'b0;
        o_branch_target = br_target;
        is_sw           = 1'b0;
        case (opcode)
            mips_pkg::OP_SPECIAL: begin
                id_ex_d.b  = i_rt_val;
                id_ex_d.rd = i_instr[15:11];
                id_ex_d.we = 1'b1;
                case (funct)
                    mips_pkg::FN_SLL: begin
                        id_ex_d.alu_op = mips_pkg::ALU_SLL;
                        id_ex_d.a      = {{(mips_pkg::XLEN-5){1'b0}}, i_instr[10:6]};
                    end
                    mips_pkg::FN_SRL: begin
                        id_ex_d.alu_op = mips_pkg::ALU_SRL;
                        id_ex_d.a      = {{(mips_pkg::XLEN-5){1'b0}}, i_instr[10:6]};
                    end
                    mips_pkg::FN_JR: begin
                        id_ex_d.we      = 1'b0;
                        o_branch_taken  = 1'b1;
                        o_branch_target = i_rs_val;
                    end
                    mips_pkg::FN_ADDU: id_ex_d.alu_op = mips_pkg::ALU_ADD;
                    mips_pkg::FN_SUBU: id_ex_d.alu_op = mips_pkg::ALU_SUB;
                    mips_pkg::FN_AND:  id_ex_d.alu_op = mips_pkg::ALU_AND;
                    mips_pkg::FN_OR:   id_ex_d.alu_op = mips_pkg::ALU_OR;
                    mips_pkg::FN_XOR:  id_ex_d.alu_op = mips_pkg::ALU_XOR;
                    mips_pkg::FN_NOR:  id_ex_d.alu_op = mips_pkg::ALU_NOR;
                    mips_pkg::FN_SLT:  id_ex_d.alu_op = mips_pkg::ALU_SLT;
                    mips_pkg::FN_SLTU: id_ex_d.alu_op = mips_pkg::ALU_SLTU;
                    default:           id_ex_d.we = 1'b0;
                endcase
            end
            mips_pkg::OP_J: begin
                o_branch_taken  = 1'b1;
                o_branch_target = jmp_target;
            end
            mips_pkg::OP_JAL: begin
                o_branch_taken  = 1'b1;
                o_branch_target = jmp_target;
                id_ex_d.res_src = mips_pkg::RES_LINK;
                id_ex_d.rd      = mips_pkg::LINK_REG;
                id_ex_d.we      = 1'b1;
            end
            mips_pkg::OP_BEQ: o_branch_taken = (i_rs_val == i_rt_val);
            mips_pkg::OP_BNE: o_branch_taken = (i_rs_val != i_rt_val);
            mips_pkg::OP_ADDIU: id_ex_d.we = 1'b1;
            mips_pkg::OP_SLTI: begin
                id_ex_d.alu_op = mips_pkg::ALU_SLT;
                id_ex_d.we     = 1'b1;
            end
            mips_pkg::OP_ANDI: begin
                id_ex_d.alu_op = mips_pkg::ALU_AND;
                id_ex_d.b      = imm_zext;
                id_ex_d.we     = 1'b1;
            end
            mips_pkg::OP_ORI: begin
                id_ex_d.alu_op = mips_pkg::ALU_OR;
                id_ex_d.b      = imm_zext;
                id_ex_d.we     = 1'b1;
            end
            mips_pkg::OP_XORI: begin
                id_ex_d.alu_op = mips_pkg::ALU_XOR;
                id_ex_d.b      = imm_zext;
                id_ex_d.we     = 1'b1;
            end
            mips_pkg::OP_LUI: begin
                id_ex_d.alu_op = mips_pkg::ALU_LUI;
                id_ex_d.b      = imm_zext;
                id_ex_d.we     = 1'b1;
            end
            mips_pkg::OP_LW: begin
                id_ex_d.res_src = mips_pkg::RES_LOAD;
                id_ex_d.we      = 1'b1;
            end
            mips_pkg::OP_SW: is_sw = 1'b1;
            default: ;
        endcase
    end

    // Loads also present their address here, read data follows in EXE
    assign o_dmem_addr  = i_rs_val + imm_sext;
    assign o_dmem_wdata = i_rt_val;
    assign o_dmem_we    = is_sw && !i_stall;

    always_ff @(posedge i_clk) begin
        o_id_ex <= id_ex_d;
        if (!i_rst_n || i_stall) begin
            o_id_ex.we <= 1'b0;
        end
    end

    a_store_aligned: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        o_dmem_we |-> o_dmem_addr[1:0] == 2'b00);

    // The bubble behind a load clears the hazard on the next cycle
    a_single_stall: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_stall |=> !i_stall);

endmodule

`default_nettype wire

// File: src/execute_stage.sv
`timescale 1ns/1ps
`default_nettype none

module execute_stage (
    input  logic                      i_clk,
    input  logic                      i_rst_n,
    input  mips_pkg::id_ex_t          i_id_ex,
    input  logic [mips_pkg::XLEN-1:0] i_dmem_rdata,
    output mips_pkg::fwd_t            o_ex_fwd,
    output mips_pkg::ex_mem_t         o_ex_mem
);

    logic [mips_pkg::XLEN-1:0] alu_result;
    logic [mips_pkg::XLEN-1:0] ex_result;

    alu u_alu (
        .i_op    (i_id_ex.alu_op),
        .i_a     (i_id_ex.a),
        .i_b     (i_id_ex.b),
        .o_result(alu_result)
    );

    // jal links past its delay slot
    assign ex_result = (i_id_ex.res_src == mips_pkg::RES_LINK) ? i_id_ex.pc + 8 : alu_result;

    assign o_ex_fwd.valid = (i_id_ex.res_src != mips_pkg::RES_LOAD);
    assign o_ex_fwd.we    = i_id_ex.we;
    assign o_ex_fwd.addr  = i_id_ex.rd;
    assign o_ex_fwd.data  = ex_result;

    always_ff @(posedge i_clk) begin
        o_ex_mem.result    <= ex_result;
        o_ex_mem.load_data <= i_dmem_rdata;
        o_ex_mem.res_src   <= i_id_ex.res_src;
        o_ex_mem.rd        <= i_id_ex.rd;
        o_ex_mem.we        <= i_rst_n && i_id_ex.we;
    end

endmodule

`default_nettype wire

// File: src/fetch_stage.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_stage (
    input  logic                      i_clk,
    input  logic                      i_rst_n,
    input  logic                      i_stall,
    input  logic                      i_branch_taken,
    input  logic [mips_pkg::XLEN-1:0] i_branch_target,
    input  logic [mips_pkg::XLEN-1:0] i_imem_rdata,
    output logic [mips_pkg::XLEN-1:0] o_imem_raddr,
    output logic [mips_pkg::XLEN-1:0] o_id_pc,
    output logic [mips_pkg::XLEN-1:0] o_id_instr
);

    logic [mips_pkg::XLEN-1:0] pc;

    assign o_imem_raddr = pc;

    // Branch in ID redirects after the delay slot now in IF
    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            pc <= mips_pkg::RESET_PC;
        end else if (!i_stall) begin
            pc <= i_branch_taken ? i_branch_target : pc + 4;
        end
    end

    // Reset leaves a nop (sll r0) in IF/ID
    always_ff @(posedge i_clk) begin
        if (!i_stall) begin
            o_id_pc    <= pc;
            o_id_instr <= i_imem_rdata;
        end
        if (!i_rst_n) begin
            o_id_instr <= '0;
        end
    end

    a_pc_aligned: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        pc[1:0] == 2'b00);

endmodule

`default_nettype wire

// File: src/hazard_unit.sv
`timescale 1ns/1ps
`default_nettype none

module hazard_unit (
    input  logic [mips_pkg::REG_ADDR_W-1:0] i_rs_addr,
    input  logic [mips_pkg::REG_ADDR_W-1:0] i_rt_addr,
    input  logic [mips_pkg::XLEN-1:0]       i_rs_data,
    input  logic [mips_pkg::XLEN-1:0]       i_rt_data,
    input  mips_pkg::fwd_t                  i_ex_fwd,
    input  mips_pkg::fwd_t                  i_mem_fwd,
    output logic [mips_pkg::XLEN-1:0]       o_rs_val,
    output logic [mips_pkg::XLEN-1:0]       o_rt_val,
    output logic                            o_stall
);

    function automatic logic hits(input mips_pkg::fwd_t src,
                                  input logic [mips_pkg::REG_ADDR_W-1:0] addr);
        return src.we && (src.addr != '0) && (src.addr == addr);
    endfunction

    // EXE wins over MEM, the register file covers WB
    function automatic logic [mips_pkg::XLEN-1:0] bypass(
        input logic [mips_pkg::REG_ADDR_W-1:0] addr,
        input logic [mips_pkg::XLEN-1:0]       rf_data,
        input mips_pkg::fwd_t                  ex_src,
        input mips_pkg::fwd_t                  mem_src
    );
        logic [mips_pkg::XLEN-1:0] val;
        val = rf_data;
        if (hits(ex_src, addr) && ex_src.valid) begin
            val = ex_src.data;
        end else if (hits(mem_src, addr) && mem_src.valid) begin
            val = mem_src.data;
        end
        return val;
    endfunction

    assign o_rs_val = bypass(i_rs_addr, i_rs_data, i_ex_fwd, i_mem_fwd);
    assign o_rt_val = bypass(i_rt_addr, i_rt_data, i_ex_fwd, i_mem_fwd);

    // Load in EXE, data not there until MEM
    assign o_stall = !i_ex_fwd.valid
                     && (hits(i_ex_fwd, i_rs_addr) || hits(i_ex_fwd, i_rt_addr));

endmodule

`default_nettype wire

// File: src/memory_stage.sv
`timescale 1ns/1ps
`default_nettype none

module memory_stage (
    input  logic              i_clk,
    input  logic              i_rst_n,
    input  mips_pkg::ex_mem_t i_ex_mem,
    output mips_pkg::fwd_t    o_mem_fwd,
    output mips_pkg::wb_t     o_wb
);

    logic [mips_pkg::XLEN-1:0] final_val;

    assign final_val = (i_ex_mem.res_src == mips_pkg::RES_LOAD) ? i_ex_mem.load_data
                                                                : i_ex_mem.result;

    // Every value is known by MEM
    assign o_mem_fwd.valid = 1'b1;
    assign o_mem_fwd.we    = i_ex_mem.we;
    assign o_mem_fwd.addr  = i_ex_mem.rd;
    assign o_mem_fwd.data  = final_val;

    always_ff @(posedge i_clk) begin
        o_wb.addr <= i_ex_mem.rd;
        o_wb.data <= final_val;
        o_wb.we   <= i_rst_n && i_ex_mem.we;
    end

endmodule

`default_nettype wire

// File: src/mips_core.sv
`timescale 1ns/1ps
`default_nettype none

module mips_core (
    input  logic                      i_clk,
    input  logic                      i_rst_n,
    output logic [mips_pkg::XLEN-1:0] o_imem_raddr,
    input  logic [mips_pkg::XLEN-1:0] i_imem_rdata,
    output logic [mips_pkg::XLEN-1:0] o_dmem_addr,
    output logic [mips_pkg::XLEN-1:0] o_dmem_wdata,
    output logic                      o_dmem_we,
    input  logic [mips_pkg::XLEN-1:0] i_dmem_rdata
);

    logic [mips_pkg::XLEN-1:0]       id_pc;
    logic [mips_pkg::XLEN-1:0]       id_instr;
    logic                            branch_taken;
    logic [mips_pkg::XLEN-1:0]       branch_target;
    logic [mips_pkg::REG_ADDR_W-1:0] rs_addr;
    logic [mips_pkg::REG_ADDR_W-1:0] rt_addr;
    logic [mips_pkg::XLEN-1:0]       rs_data;
    logic [mips_pkg::XLEN-1:0]       rt_data;
    logic [mips_pkg::XLEN-1:0]       rs_val;
    logic [mips_pkg::XLEN-1:0]       rt_val;
    logic                            stall;

    mips_pkg::id_ex_t  id_ex;
    mips_pkg::ex_mem_t ex_mem;
    mips_pkg::fwd_t    ex_fwd;
    mips_pkg::fwd_t    mem_fwd;
    mips_pkg::wb_t     wb;

    fetch_stage u_fetch (
        .i_clk          (i_clk),
        .i_rst_n        (i_rst_n),
        .i_stall        (stall),
        .i_branch_taken (branch_taken),
        .i_branch_target(branch_target),
        .i_imem_rdata   (i_imem_rdata),
        .o_imem_raddr   (o_imem_raddr),
        .o_id_pc        (id_pc),
        .o_id_instr     (id_instr)
    );

    decode_stage u_decode (
        .i_clk          (i_clk),
        .i_rst_n        (i_rst_n),
        .i_stall        (stall),
        .i_pc           (id_pc),
        .i_instr        (id_instr),
        .i_rs_val       (rs_val),
        .i_rt_val       (rt_val),
        .o_rs_addr      (rs_addr),
        .o_rt_addr      (rt_addr),
        .o_branch_taken (branch_taken),
        .o_branch_target(branch_target),
        .o_dmem_addr    (o_dmem_addr),
        .o_dmem_wdata   (o_dmem_wdata),
        .o_dmem_we      (o_dmem_we),
        .o_id_ex        (id_ex)
    );

    reg_file u_reg_file (
        .i_clk    (i_clk),
        .i_rst_n  (i_rst_n),
        .i_rs_addr(rs_addr),
        .i_rt_addr(rt_addr),
        .i_wb     (wb),
        .o_rs_data(rs_data),
        .o_rt_data(rt_data)
    );

    hazard_unit u_hazard (
        .i_rs_addr(rs_addr),
        .i_rt_addr(rt_addr),
        .i_rs_data(rs_data),
        .i_rt_data(rt_data),
        .i_ex_fwd (ex_fwd),
        .i_mem_fwd(mem_fwd),
        .o_rs_val (rs_val),
        .o_rt_val (rt_val),
        .o_stall  (stall)
    );

    execute_stage u_execute (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .i_id_ex     (id_ex),
        .i_dmem_rdata(i_dmem_rdata),
        .o_ex_fwd    (ex_fwd),
        .o_ex_mem    (ex_mem)
    );

    memory_stage u_memory (
        .i_clk    (i_clk),
        .i_rst_n  (i_rst_n),
        .i_ex_mem (ex_mem),
        .o_mem_fwd(mem_fwd),
        .o_wb     (wb)
    );

endmodule

`default_nettype wire

// File: src/mips_pkg.sv
`default_nettype none

package mips_pkg;

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;
    localparam int NUM_REGS   = 32;

    localparam logic [XLEN-1:0]       RESET_PC = 32'h0040_0000;
    localparam logic [REG_ADDR_W-1:0] LINK_REG = 5'd31;

    typedef enum logic [5:0] {
        OP_SPECIAL = 6'h00,
        OP_J       = 6'h02,
        OP_JAL     = 6'h03,
        OP_BEQ     = 6'h04,
        OP_BNE     = 6'h05,
        OP_ADDIU   = 6'h09,
        OP_SLTI    = 6'h0a,
        OP_ANDI    = 6'h0c,
        OP_ORI     = 6'h0d,
        OP_XORI    = 6'h0e,
        OP_LUI     = 6'h0f,
        OP_LW      = 6'h23,
        OP_SW      = 6'h2b
    } opcode_e;

    typedef enum logic [5:0] {
        FN_SLL  = 6'h00,
        FN_SRL  = 6'h02,
        FN_JR   = 6'h08,
        FN_ADDU = 6'h21,
        FN_SUBU = 6'h23,
        FN_AND  = 6'h24,
        FN_OR   = 6'h25,
        FN_XOR  = 6'h26,
        FN_NOR  = 6'h27,
        FN_SLT  = 6'h2a,
        FN_SLTU = 6'h2b
    } funct_e;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_NOR,
        ALU_SLT,
        ALU_SLTU,
        ALU_SLL,
        ALU_SRL,
        ALU_LUI
    } alu_op_e;

    // Source of the value written to the destination register
    typedef enum logic [1:0] {
        RES_ALU,
        RES_LINK,
        RES_LOAD
    } res_src_e;

    typedef struct packed {
        logic [XLEN-1:0]       pc;
        alu_op_e               alu_op;
        logic [XLEN-1:0]       a;
        logic [XLEN-1:0]       b;
        res_src_e              res_src;
        logic [REG_ADDR_W-1:0] rd;
        logic                  we;
    } id_ex_t;

    typedef struct packed {
        logic [XLEN-1:0]       result;
        logic [XLEN-1:0]       load_data;
        res_src_e              res_src;
        logic [REG_ADDR_W-1:0] rd;
        logic                  we;
    } ex_mem_t;

    typedef struct packed {
        logic                  we;
        logic [REG_ADDR_W-1:0] addr;
        logic [XLEN-1:0]       data;
    } wb_t;

    // valid is low while the value is not yet known (load in EXE)
    typedef struct packed {
        logic                  valid;
        logic                  we;
        logic [REG_ADDR_W-1:0] addr;
        logic [XLEN-1:0]       data;
    } fwd_t;

endpackage

`default_nettype wire

// File: src/reg_file.sv
`timescale 1ns/1ps
`default_nettype none

module reg_file (
    input  logic                            i_clk,
    input  logic                            i_rst_n,
    input  logic [mips_pkg::REG_ADDR_W-1:0] i_rs_addr,
    input  logic [mips_pkg::REG_ADDR_W-1:0] i_rt_addr,
    input  mips_pkg::wb_t                   i_wb,
    output logic [mips_pkg::XLEN-1:0]       o_rs_data,
    output logic [mips_pkg::XLEN-1:0]       o_rt_data
);

    logic [mips_pkg::XLEN-1:0] regs [mips_pkg::NUM_REGS];
    logic                      wr_en;

    assign wr_en = i_rst_n && i_wb.we && (i_wb.addr != '0);

    always_ff @(posedge i_clk) begin
        if (wr_en) begin
            regs[i_wb.addr] <= i_wb.data;
        end
    end

    // Write-through covers the WB stage
    always_comb begin
        o_rs_data = regs[i_rs_addr];
        o_rt_data = regs[i_rt_addr];
        if (wr_en && i_wb.addr == i_rs_addr) begin
            o_rs_data = i_wb.data;
        end
        if (wr_en && i_wb.addr == i_rt_addr) begin
            o_rt_data = i_wb.data;
        end
        if (i_rs_addr == '0) begin
            o_rs_data = '0;
        end
        if (i_rt_addr == '0) begin
            o_rt_data = '0;
        end
    end

endmodule

`default_nettype wire

// File: testbench/tb_mips_core.sv
`timescale 1ns/1ps
`default_nettype none

module tb_mips_core;

    localparam int          IMEM_WORDS  = 64;
    localparam int          SUB_IDX     = 52;
    localparam logic [31:0] MARKER_ADDR = 32'h0000_03fc;

    // MIPS primary opcodes
    localparam int OP_J     = 'h02;
    localparam int OP_JAL   = 'h03;
    localparam int OP_BEQ   = 'h04;
    localparam int OP_BNE   = 'h05;
    localparam int OP_ADDIU = 'h09;
    localparam int OP_ORI   = 'h0d;
    localparam int OP_LUI   = 'h0f;
    localparam int OP_LW    = 'h23;
    localparam int OP_SW    = 'h2b;

    // SPECIAL function codes
    localparam int F_SLL  = 'h00;
    localparam int F_SRL  = 'h02;
    localparam int F_JR   = 'h08;
    localparam int F_ADDU = 'h21;
    localparam int F_SUBU = 'h23;
    localparam int F_AND  = 'h24;
    localparam int F_OR   = 'h25;
    localparam int F_XOR  = 'h26;
    localparam int F_NOR  = 'h27;
    localparam int F_SLT  = 'h2a;
    localparam int F_SLTU = 'h2b;

    typedef struct packed {
        logic [31:0] addr;
        logic [31:0] data;
    } store_t;

    typedef struct packed {
        logic        we;
        logic [31:0] addr;
        logic [31:0] data;
    } dmem_req_t;

    logic        clk;
    logic        rst_n;
    logic [31:0] imem_raddr;
    logic [31:0] imem_rdata;
    logic [31:0] dmem_addr;
    logic [31:0] dmem_wdata;
    logic        dmem_we;
    logic [31:0] dmem_rdata;

    logic [31:0] prog [$];
    store_t      expected [$];
    logic [31:0] imem [IMEM_WORDS];
    logic [31:0] dmem [256];
    dmem_req_t   req;
    bit          prog_loaded = 1'b0;

    mips_core uut (
        .i_clk       (clk),
        .i_rst_n     (rst_n),
        .o_imem_raddr(imem_raddr),
        .i_imem_rdata(imem_rdata),
        .o_dmem_addr (dmem_addr),
        .o_dmem_wdata(dmem_wdata),
        .o_dmem_we   (dmem_we),
        .i_dmem_rdata(dmem_rdata)
    );

    always #5 clk = ~clk;

    function automatic logic [31:0] rtype(input int funct, input int rd, input int rs,
                                          input int rt, input int shamt);
        return {6'h00, rs[4:0], rt[4:0], rd[4:0], shamt[4:0], funct[5:0]};
    endfunction

    function automatic logic [31:0] itype(input int op, input int rt, input int rs,
                                          input int imm);
        return {op[5:0], rs[4:0], rt[4:0], imm[15:0]};
    endfunction

    function automatic logic [31:0] jtype(input int op, input int idx);
        logic [31:0] target;
        target = mips_pkg::RESET_PC + 32'(4 * idx);
        return {op[5:0], target[27:2]};
    endfunction

    function automatic logic [31:0] fetch_word(input logic [31:0] addr);
        logic [31:0] idx;
        idx = (addr - mips_pkg::RESET_PC) >> 2;
        if (idx < IMEM_WORDS) begin
            return imem[idx[5:0]];
        end
        return 32'h0;
    endfunction

    task automatic emit(input logic [31:0] instr);
        prog.push_back(instr);
    endtask

    task automatic expect_store(input logic [31:0] addr, input logic [31:0] data);
        store_t s;
        s.addr = addr;
        s.data = data;
        expected.push_back(s);
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("Error: time %0t, %s = %h, expected %h", $time, name, got, exp);
            $display("Verification failed");
            $fatal(1, "value mismatch");
        end
    endtask

    initial begin
        clk        = 1'b0;
        rst_n      = 1'b0;
        imem_rdata = 32'h0;
        dmem_rdata = 32'h0;
        req        = '0;
        repeat (3) @(posedge clk);
        #1;
        rst_n = 1'b1;
    end

    // No store during reset, fetch starts at the reset vector
    initial begin : reset_checks
        @(posedge clk);
        while (!rst_n) begin
            @(negedge clk);
            check_value("o_dmem_we", {31'h0, dmem_we}, 32'h0);
            check_value("o_imem_raddr", imem_raddr, mips_pkg::RESET_PC);
        end
    end

    initial begin : build_program
        logic [31:0] v [32];
        int          jal_idx;
        logic [31:0] link;

        for (int i = 0; i < 256; i++) begin
            dmem[i[7:0]] = 32'ha5a5_0000 | 32'(i << 2);
        end

        // Dependent ALU chain
        emit(itype(OP_ADDIU, 1, 0, 'h1234));
        v[1] = 32'h0000_1234;
        emit(itype(OP_ADDIU, 2, 0, -16));
        v[2] = 32'hffff_fff0;
        emit(rtype(F_ADDU, 3, 1, 2, 0));
        v[3] = v[1] + v[2];
        emit(rtype(F_SUBU, 4, 3, 1, 0));
        v[4] = v[3] - v[1];
        emit(rtype(F_AND, 5, 4, 1, 0));
        v[5] = v[4] & v[1];
        emit(rtype(F_OR, 6, 5, 2, 0));
        v[6] = v[5] | v[2];
        emit(rtype(F_XOR, 7, 6, 1, 0));
        v[7] = v[6] ^ v[1];
        emit(rtype(F_NOR, 8, 7, 0, 0));
        v[8] = ~(v[7] | 32'h0);
        emit(rtype(F_SLT, 9, 2, 1, 0));
        v[9] = {31'h0, $signed(v[2]) < $signed(v[1])};
        emit(rtype(F_SLTU, 10, 2, 1, 0));
        v[10] = {31'h0, v[2] < v[1]};
        emit(rtype(F_SLL, 11, 0, 8, 4));
        v[11] = v[8] << 4;
        emit(rtype(F_SRL, 12, 0, 11, 8));
        v[12] = v[11] >> 8;
        emit(itype(OP_LUI, 13, 0, 'habcd));
        v[13] = 32'habcd_0000;
        emit(itype(OP_ORI, 14, 13, 'h5678));
        v[14] = v[13] | 32'h0000_5678;

        // Store data straight from EXE
        emit(itype(OP_SW, 14, 0, 'h12c));
        expect_store(32'h12c, v[14]);
        for (int k = 3; k <= 13; k++) begin
            emit(itype(OP_SW, k, 0, 'h100 + 4 * (k - 3)));
            expect_store(32'h100 + 32'(4 * (k - 3)), v[k[4:0]]);
        end

        // Base register bypassed into the address
        emit(itype(OP_ADDIU, 15, 0, 'h200));
        v[15] = 32'h200;
        emit(itype(OP_SW, 1, 15, 'h10));
        expect_store(v[15] + 32'h10, v[1]);

        // Load-use pairs
        emit(itype(OP_LW, 16, 0, 'h100));
        emit(rtype(F_ADDU, 17, 16, 1, 0));
        emit(itype(OP_SW, 17, 0, 'h220));
        expect_store(32'h220, v[3] + v[1]);
        emit(itype(OP_LW, 18, 0, 'h104));
        emit(itype(OP_SW, 18, 0, 'h224));
        expect_store(32'h224, v[4]);

        emit(itype(OP_ADDIU, 19, 0, 5));
        emit(itype(OP_ADDIU, 20, 0, 5));
        emit(itype(OP_BEQ, 20, 19, 2));
        emit(itype(OP_SW, 19, 0, 'h230));
        expect_store(32'h230, 32'd5);
        // Skipped by the taken beq
        emit(itype(OP_SW, 1, 0, 'h234));
        emit(itype(OP_BNE, 20, 19, 3));
        emit(itype(OP_SW, 20, 0, 'h238));
        expect_store(32'h238, 32'd5);
        emit(itype(OP_SW, 2, 0, 'h23c));
        expect_store(32'h23c, v[2]);

        jal_idx = prog.size();
        emit(jtype(OP_JAL, SUB_IDX));
        emit(itype(OP_ADDIU, 21, 0, 7));
        emit(itype(OP_SW, 31, 0, 'h240));
        emit(itype(OP_SW, 21, 0, 'h244));
        link = mips_pkg::RESET_PC + 32'(4 * (jal_idx + 2));
        // Subroutine store in the jr delay slot lands first
        expect_store(32'h24c, 32'h77);
        expect_store(32'h240, link);
        expect_store(32'h244, 32'd7);

        emit(itype(OP_ADDIU, 0, 0, 'h55));
        emit(itype(OP_SW, 0, 0, 'h248));
        expect_store(32'h248, 32'h0);

        // End marker, then spin in place
        emit(itype(OP_SW, 0, 0, MARKER_ADDR));
        emit(jtype(OP_J, prog.size()));
        emit(32'h0);
        while (prog.size() < SUB_IDX) begin
            emit(32'h0);
        end
        emit(itype(OP_ADDIU, 22, 0, 'h77));
        emit(rtype(F_JR, 0, 31, 0, 0));
        emit(itype(OP_SW, 22, 0, 'h24c));

        for (int i = 0; i < IMEM_WORDS; i++) begin
            imem[i[5:0]] = (i < prog.size()) ? prog[i] : 32'h0;
        end
        prog_loaded = 1'b1;
    end

    // Requests are settled by the falling edge
    always @(negedge clk) begin
        req.we   = dmem_we && rst_n;
        req.addr = dmem_addr;
        req.data = dmem_wdata;
    end

    always @(posedge clk) begin
        #1;
        imem_rdata = fetch_word(imem_raddr);
        if (req.we) begin
            dmem[req.addr[9:2]] = req.data;
        end
        dmem_rdata = dmem[req.addr[9:2]];
    end

    initial begin : store_monitor
        int n;
        n = 0;
        wait (prog_loaded && rst_n);
        forever begin
            @(negedge clk);
            if (dmem_we) begin
                if (dmem_addr == MARKER_ADDR) begin
                    break;
                end
                if (n >= expected.size()) begin
                    $display("Store to %h at time %0t is not in the expected table",
                             dmem_addr, $time);
                    $display("Verification failed");
                    $fatal(1, "unexpected store");
                end else begin
                    check_value("o_dmem_addr", dmem_addr, expected[n].addr);
                    check_value("o_dmem_wdata", dmem_wdata, expected[n].data);
                    n++;
                end
            end
        end
        check_value("store count", n, expected.size());
        $display("Verification passed");
        $finish;
    end

    initial begin : watchdog
        wait (prog_loaded);
        repeat (prog.size() * 20) @(posedge clk);
        $display("Timeout at %0t: the program did not reach its end marker", $time);
        $display("Verification failed");
        $fatal(1, "watchdog expired");
    end

endmodule

`default_nettype wire

// File: vlog.f
src/mips_pkg.sv
src/alu.sv
src/reg_file.sv
src/hazard_unit.sv
src/fetch_stage.sv
src/decode_stage.sv
src/execute_stage.sv
src/memory_stage.sv
src/mips_core.sv
testbench/tb_mips_core.sv
